// ==== hdl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path width
`define CPU_WORD_W     16

// Word address into the external memory
`define CPU_ADDR_W     9

// Register file
`define CPU_REG_IDX_W  3
`define CPU_REG_NUM    8

// First instruction fetched after reset
`define CPU_RESET_PC   9'd0

`endif

// ==== hdl/isa_pkg.sv ====
`include "cpu_consts.svh"

package isa_pkg;

    typedef enum logic [2:0]
    {
        MOV    = 3'b110,
        ALU    = 3'b101,
        LDR    = 3'b011,
        STR    = 3'b100,
        BRANCH = 3'b001,
        HALT   = 3'b111
    } opcode_e;

    // Branch condition, carried in the Rn field
    typedef enum logic [2:0]
    {
        ALWAYS = 3'b000,
        EQ     = 3'b001,
        NE     = 3'b010,
        LT     = 3'b011,
        LE     = 3'b100
    } cond_e;

    typedef enum logic [1:0]
    {
        ADD = 2'b00,
        CMP = 2'b01,
        AND = 2'b10,
        MVN = 2'b11
    } alu_op_e;

    typedef struct packed
    {
        opcode_e                   opcode;
        logic [1:0]                op;
        cond_e                     cond;
        logic [`CPU_REG_IDX_W-1:0] rn;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic [`CPU_REG_IDX_W-1:0] rm;
        logic [`CPU_WORD_W-1:0]    sximm5;
        logic [`CPU_WORD_W-1:0]    sximm8;
    } decoded_t;

    typedef struct packed
    {
        logic n;
        logic v;
        logic z;
    } status_t;

    typedef enum logic [1:0]
    {
        RN = 2'b00,
        RD = 2'b01,
        RM = 2'b10
    } reg_sel_e;

    // Register file write-back source
    typedef enum logic [1:0]
    {
        WB_C     = 2'b00,
        WB_IMM   = 2'b01,
        WB_MDATA = 2'b10
    } wb_sel_e;

    typedef struct packed
    {
        reg_sel_e nsel;
        wb_sel_e  wb_sel;
        logic     load_a;
        logic     load_b;
        logic     asel;     // Zero operand A
        logic     bsel;     // sximm5 in place of B
        logic     load_c;
        logic     load_s;
        logic     write;
    } dp_ctrl_t;

    typedef enum logic [1:0]
    {
        PC_INC    = 2'b00,
        PC_BRANCH = 2'b01,
        PC_RESET  = 2'b10
    } pc_sel_e;

    typedef struct packed
    {
        logic    load_ir;
        logic    load_pc;
        pc_sel_e pc_sel;
        logic    load_addr;
        logic    addr_sel;  // 1 puts the PC on the bus
    } fetch_ctrl_t;

endpackage

// ==== hdl/bus_pkg.sv ====
`include "cpu_consts.svh"

package bus_pkg;

    typedef enum logic [1:0]
    {
        NONE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b11
    } mem_cmd_e;

    // Single memory port, no handshake
    typedef struct packed
    {
        mem_cmd_e               cmd;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_WORD_W-1:0] wdata;
    } mem_req_t;

endpackage

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_decode
(
    input  logic [`CPU_WORD_W-1:0] instr,
    output isa_pkg::decoded_t      dec
);

    localparam int MSB = `CPU_WORD_W - 1;

    always_comb
    begin
        dec.opcode = isa_pkg::opcode_e'(instr[15:13]);
        dec.op     = instr[12:11];
        dec.cond   = isa_pkg::cond_e'(instr[10:8]);    // Branches reuse the Rn bits
        dec.rn     = instr[10:8];
        dec.rd     = instr[7:5];
        dec.rm     = instr[2:0];

        // Shift field 4:3 is not decoded
        dec.sximm5 = {{(MSB - 4){instr[4]}}, instr[4:0]};
        dec.sximm8 = {{(MSB - 7){instr[7]}}, instr[7:0]};
    end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_unit
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CPU_WORD_W-1:0]  read_data,
    input  isa_pkg::fetch_ctrl_t    ctrl,
    input  logic [`CPU_ADDR_W-1:0]  branch_offset,
    input  logic [`CPU_WORD_W-1:0]  c_value,
    output logic [`CPU_WORD_W-1:0]  instr,
    output logic [`CPU_ADDR_W-1:0]  mem_addr
);

    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] next_pc;
    logic [`CPU_ADDR_W-1:0] data_addr;

    always_comb
    begin
        case (ctrl.pc_sel)
            isa_pkg::PC_BRANCH: next_pc = pc + branch_offset;   // PC already incremented
            isa_pkg::PC_RESET:  next_pc = `CPU_RESET_PC;
            default:            next_pc = pc + 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `CPU_RESET_PC;
        else if (ctrl.load_pc)
            pc <= next_pc;
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.load_ir)
            instr <= read_data;
        if (ctrl.load_addr)
            data_addr <= c_value[`CPU_ADDR_W-1:0];
    end

    assign mem_addr = ctrl.addr_sel ? pc : data_addr;

    // Instruction and data address never captured in the same cycle
    a_ir_addr_excl: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.load_ir && ctrl.load_addr));

endmodule

// ==== hdl/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm
(
    input  logic                  clk,
    input  logic                  reset,
    input  isa_pkg::decoded_t     dec,
    input  isa_pkg::status_t      status,
    output isa_pkg::dp_ctrl_t     dp_ctrl,
    output isa_pkg::fetch_ctrl_t  fetch_ctrl,
    output bus_pkg::mem_cmd_e     mem_cmd,
    output logic                  halt
);

    typedef enum logic [4:0]
    {
        S_RST, S_IF1, S_IF2, S_UPDATE, S_DECODE,
        S_MOVI, S_GET_A, S_GET_B, S_ALU_OP, S_WB,
        S_ADDR_C, S_LOAD_ADDR, S_ADDR_SET, S_MEM_RD, S_LD_WB,
        S_WR_SETUP, S_MEM_WR, S_BRANCH, S_HALT
    } state_e;

    state_e state;
    state_e next_state;
    logic   taken;
    logic   is_cmp;

    assign is_cmp = (dec.opcode == isa_pkg::ALU) && (dec.op == isa_pkg::CMP);

    always_comb
    begin
        case (dec.cond)
            isa_pkg::ALWAYS: taken = 1'b1;
            isa_pkg::EQ:     taken = status.z;
            isa_pkg::NE:     taken = !status.z;
            isa_pkg::LT:     taken = status.n ^ status.v;
            isa_pkg::LE:     taken = (status.n ^ status.v) | status.z;
            default:         taken = 1'b0;
        endcase
    end

    always_comb
    begin
        next_state = state;
        case (state)
            S_RST:    next_state = S_IF1;
            S_IF1:    next_state = S_IF2;
            S_IF2:    next_state = S_UPDATE;
            S_UPDATE: next_state = S_DECODE;
            S_DECODE:
            begin
                case (dec.opcode)
                    isa_pkg::MOV:    next_state = dec.op[1] ? S_MOVI : S_GET_B;
                    isa_pkg::ALU:    next_state = S_GET_A;
                    isa_pkg::LDR:    next_state = S_GET_A;
                    isa_pkg::STR:    next_state = S_GET_A;
                    isa_pkg::BRANCH: next_state = S_BRANCH;
                    default:         next_state = S_HALT;   // HALT and unknown opcodes
                endcase
            end
            S_GET_A:     next_state = (dec.opcode == isa_pkg::ALU) ? S_GET_B : S_ADDR_C;
            S_GET_B:     next_state = S_ALU_OP;
            S_ALU_OP:    next_state = (dec.opcode == isa_pkg::STR) ? S_WR_SETUP : S_WB;
            S_ADDR_C:    next_state = S_LOAD_ADDR;
            S_LOAD_ADDR: next_state = S_ADDR_SET;
            S_ADDR_SET:  next_state = (dec.opcode == isa_pkg::LDR) ? S_MEM_RD : S_GET_B;
            S_MEM_RD:    next_state = S_LD_WB;
            S_WR_SETUP:  next_state = S_MEM_WR;
            S_HALT:      next_state = S_HALT;
            default:     next_state = S_IF1;    // MOVI, WB, LD_WB, MEM_WR, BRANCH
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= S_RST;
        else
            state <= next_state;
    end

    always_comb
    begin
        dp_ctrl.nsel         = isa_pkg::RN;
        dp_ctrl.wb_sel       = isa_pkg::WB_C;
        dp_ctrl.load_a       = 1'b0;
        dp_ctrl.load_b       = 1'b0;
        dp_ctrl.asel         = 1'b0;
        dp_ctrl.bsel         = 1'b0;
        dp_ctrl.load_c       = 1'b0;
        dp_ctrl.load_s       = 1'b0;
        dp_ctrl.write        = 1'b0;
        fetch_ctrl.load_ir   = 1'b0;
        fetch_ctrl.load_pc   = 1'b0;
        fetch_ctrl.pc_sel    = isa_pkg::PC_INC;
        fetch_ctrl.load_addr = 1'b0;
        fetch_ctrl.addr_sel  = 1'b1;
        mem_cmd              = bus_pkg::NONE;
        halt                 = 1'b0;
        case (state)
            S_RST:
            begin
                fetch_ctrl.load_pc = 1'b1;
                fetch_ctrl.pc_sel  = isa_pkg::PC_RESET;
            end
            S_IF1:    mem_cmd = bus_pkg::READ;
            S_IF2:
            begin
                mem_cmd            = bus_pkg::READ;
                fetch_ctrl.load_ir = 1'b1;
            end
            S_UPDATE: fetch_ctrl.load_pc = 1'b1;
            S_MOVI:
            begin
                dp_ctrl.wb_sel = isa_pkg::WB_IMM;
                dp_ctrl.write  = 1'b1;
            end
            S_GET_A:  dp_ctrl.load_a = 1'b1;
            S_GET_B:
            begin
                dp_ctrl.nsel   = (dec.opcode == isa_pkg::STR) ? isa_pkg::RD : isa_pkg::RM;
                dp_ctrl.load_b = 1'b1;
            end
            S_ALU_OP:
            begin
                dp_ctrl.asel   = (dec.opcode != isa_pkg::ALU);  // MOV and STR pass B
                dp_ctrl.load_c = !is_cmp;
                dp_ctrl.load_s = is_cmp;
            end
            S_WB:
            begin
                dp_ctrl.nsel  = isa_pkg::RD;
                dp_ctrl.write = !is_cmp;
            end
            S_ADDR_C:
            begin
                dp_ctrl.bsel   = 1'b1;
                dp_ctrl.load_c = 1'b1;
            end
            S_LOAD_ADDR: fetch_ctrl.load_addr = 1'b1;
            S_ADDR_SET:  fetch_ctrl.addr_sel = 1'b0;
            S_MEM_RD:
            begin
                fetch_ctrl.addr_sel = 1'b0;
                mem_cmd             = bus_pkg::READ;
            end
            S_LD_WB:
            begin
                fetch_ctrl.addr_sel = 1'b0;
                mem_cmd             = bus_pkg::READ;   // Keep read data valid for the write
                dp_ctrl.nsel        = isa_pkg::RD;
                dp_ctrl.wb_sel      = isa_pkg::WB_MDATA;
                dp_ctrl.write       = 1'b1;
            end
            S_WR_SETUP: fetch_ctrl.addr_sel = 1'b0;
            S_MEM_WR:
            begin
                fetch_ctrl.addr_sel = 1'b0;
                mem_cmd             = bus_pkg::WRITE;
            end
            S_BRANCH:
            begin
                fetch_ctrl.load_pc = taken;
                fetch_ctrl.pc_sel  = isa_pkg::PC_BRANCH;
            end
            S_HALT:   halt = 1'b1;
            default:  halt = 1'b0;
        endcase
    end

    a_no_write_halted: assert property (@(posedge clk) disable iff (reset)
        halt |-> mem_cmd != bus_pkg::WRITE);

    // Only reset leaves the halt state
    a_halt_sticky: assert property (@(posedge clk)
        (halt && !reset) |=> halt);

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module datapath
(
    input  logic                    clk,
    input  isa_pkg::decoded_t       dec,
    input  isa_pkg::dp_ctrl_t       ctrl,
    input  logic [`CPU_WORD_W-1:0]  mdata,
    output logic [`CPU_WORD_W-1:0]  c_value,
    output isa_pkg::status_t        status
);

    localparam int MSB = `CPU_WORD_W - 1;

    logic [`CPU_WORD_W-1:0]    regs [`CPU_REG_NUM];
    logic [`CPU_REG_IDX_W-1:0] rnum;
    logic [`CPU_WORD_W-1:0]    wb_data;
    logic [`CPU_WORD_W-1:0]    a_reg;
    logic [`CPU_WORD_W-1:0]    b_reg;
    logic [`CPU_WORD_W-1:0]    ain;
    logic [`CPU_WORD_W-1:0]    bin;
    logic [`CPU_WORD_W-1:0]    diff;
    logic [`CPU_WORD_W-1:0]    alu_out;
    isa_pkg::alu_op_e          alu_op;

    // One port selects both the read and the write register
    always_comb
    begin
        case (ctrl.nsel)
            isa_pkg::RD: rnum = dec.rd;
            isa_pkg::RM: rnum = dec.rm;
            default:     rnum = dec.rn;
        endcase
    end

    always_comb
    begin
        case (ctrl.wb_sel)
            isa_pkg::WB_IMM:   wb_data = dec.sximm8;
            isa_pkg::WB_MDATA: wb_data = mdata;
            default:           wb_data = c_value;
        endcase
    end

    assign ain    = ctrl.asel ? '0 : a_reg;
    assign bin    = ctrl.bsel ? dec.sximm5 : b_reg;
    assign diff   = ain - bin;
    assign alu_op = (dec.opcode == isa_pkg::ALU) ? isa_pkg::alu_op_e'(dec.op) : isa_pkg::ADD;

    always_comb
    begin
        case (alu_op)
            isa_pkg::CMP: alu_out = diff;
            isa_pkg::AND: alu_out = ain & bin;
            isa_pkg::MVN: alu_out = ~bin;
            default:      alu_out = ain + bin;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.write)
            regs[rnum] <= wb_data;
        if (ctrl.load_a)
            a_reg <= regs[rnum];
        if (ctrl.load_b)
            b_reg <= regs[rnum];
        if (ctrl.load_c)
            c_value <= alu_out;
        if (ctrl.load_s)
        begin
            status.n <= diff[MSB];
            status.v <= (ain[MSB] ^ bin[MSB]) & (diff[MSB] ^ ain[MSB]);    // Signed overflow
            status.z <= (diff == '0);
        end
    end

    a_wb_sel_legal: assert property (@(posedge clk)
        ctrl.write |-> ctrl.wb_sel inside {isa_pkg::WB_C, isa_pkg::WB_IMM, isa_pkg::WB_MDATA});

endmodule

// ==== hdl/simple_risc_top.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module simple_risc_top
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CPU_WORD_W-1:0]  read_data,
    output bus_pkg::mem_req_t       mem_req,
    output isa_pkg::status_t        status,
    output logic                    halt
);

    logic [`CPU_WORD_W-1:0] instr;
    logic [`CPU_WORD_W-1:0] c_value;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    isa_pkg::decoded_t      dec;
    isa_pkg::dp_ctrl_t      dp_ctrl;
    isa_pkg::fetch_ctrl_t   fetch_ctrl;
    bus_pkg::mem_cmd_e      mem_cmd;

    fetch_unit u_fetch
    (
        .clk           (clk),
        .reset         (reset),
        .read_data     (read_data),
        .ctrl          (fetch_ctrl),
        .branch_offset (dec.sximm8[`CPU_ADDR_W-1:0]),
        .c_value       (c_value),
        .instr         (instr),
        .mem_addr      (mem_addr)
    );

    instr_decode u_decode
    (
        .instr (instr),
        .dec   (dec)
    );

    control_fsm u_ctrl
    (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .status     (status),
        .dp_ctrl    (dp_ctrl),
        .fetch_ctrl (fetch_ctrl),
        .mem_cmd    (mem_cmd),
        .halt       (halt)
    );

    datapath u_dp
    (
        .clk     (clk),
        .dec     (dec),
        .ctrl    (dp_ctrl),
        .mdata   (read_data),
        .c_value (c_value),
        .status  (status)
    );

    // Store data always comes from C
    assign mem_req = '{cmd: mem_cmd, addr: mem_addr, wdata: c_value};

endmodule

// ==== sim/tb_simple_risc.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_simple_risc;

    localparam int ADDR_W    = `CPU_ADDR_W;
    localparam int MEM_WORDS = 1 << `CPU_ADDR_W;

    // Worst-case executed instructions per test and resets of 10 cycles each
    localparam int INSTR_TOTAL = 20 + 12 + 4 * 20 + 7 + 10 * 8 + 3 * 24 + 4;
    localparam int MAX_CYCLES  = 12 * INSTR_TOTAL + 22 * 10 + 50 + 200;

    localparam logic [7:0] DATA_BASE = 8'h70;

    logic                   clk;
    logic                   reset;
    logic                   load_mem;
    logic [`CPU_WORD_W-1:0] read_data;
    bus_pkg::mem_req_t      mem_req;
    isa_pkg::status_t       status;
    logic                   halt;

    logic [`CPU_WORD_W-1:0] mem   [MEM_WORDS];
    logic [`CPU_WORD_W-1:0] image [MEM_WORDS];
    int                     prog_len;
    int                     write_count = 0;
    int                     cycle_count = 0;
    int                     error_count = 0;
    int                     seed = 21526;

    simple_risc_top DUT
    (
        .clk       (clk),
        .reset     (reset),
        .read_data (read_data),
        .mem_req   (mem_req),
        .status    (status),
        .halt      (halt)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign read_data = (mem_req.cmd == bus_pkg::READ) ? mem[mem_req.addr] : '0;

    always @(posedge clk)
    begin
        if (load_mem)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[ADDR_W'(i)] <= image[ADDR_W'(i)];   // Program image copied in during reset
        end
        else if (mem_req.cmd == bus_pkg::WRITE)
        begin
            mem[mem_req.addr] <= mem_req.wdata;
            write_count       <= write_count + 1;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("ERROR: the run timed out after %0d cycles", cycle_count);
            $display("Finished with errors");
            $fatal(1, "Timeout");
        end
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check(string name, logic [15:0] actual, logic [15:0] expected);
        if (actual !== expected)
        begin
            error_count++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_word(logic [8:0] addr, logic [15:0] expected);
        check($sformatf("mem[0x%h]", addr), mem[addr], expected);
    endtask

    function automatic logic [15:0] sext8(logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    function automatic logic [15:0] fill_word(logic [8:0] addr);
        return 16'hc3a0 ^ 16'(addr);
    endfunction

    // Instruction words: opcode 15:13, op 12:11, Rn 10:8, Rd 7:5, Rm 2:0
    function automatic logic [15:0] mov_imm_word(logic [2:0] rn, logic [7:0] imm);
        return {3'b110, 2'b10, rn, imm};
    endfunction

    function automatic logic [15:0] mov_reg_word(logic [2:0] rd, logic [2:0] rm);
        return {3'b110, 2'b00, 3'b000, rd, 2'b00, rm};
    endfunction

    function automatic logic [15:0] alu_word(logic [1:0] op, logic [2:0] rn, logic [2:0] rd,
                                             logic [2:0] rm);
        return {3'b101, op, rn, rd, 2'b00, rm};
    endfunction

    function automatic logic [15:0] ldr_word(logic [2:0] rn, logic [2:0] rd, logic [4:0] imm);
        return {3'b011, 2'b00, rn, rd, imm};
    endfunction

    function automatic logic [15:0] str_word(logic [2:0] rn, logic [2:0] rd, logic [4:0] imm);
        return {3'b100, 2'b00, rn, rd, imm};
    endfunction

    function automatic logic [15:0] branch_word(logic [2:0] cond, logic [7:0] offset);
        return {3'b001, 2'b00, cond, offset};
    endfunction

    function automatic logic [15:0] halt_word();
        return {3'b111, 13'h0000};
    endfunction

    task automatic clear_image();
        for (int i = 0; i < MEM_WORDS; i++)
            image[ADDR_W'(i)] = fill_word(ADDR_W'(i));
        prog_len = 0;
    endtask

    task automatic emit(logic [15:0] word);
        image[ADDR_W'(prog_len)] = word;
        prog_len++;
    endtask

    task automatic apply_reset();
        step();
        reset    = 1'b1;
        load_mem = 1'b1;
        step();
        load_mem = 1'b0;
        repeat (7) step();
        check("mem_req.cmd", 16'(mem_req.cmd), 16'(bus_pkg::NONE));
        check("halt", 16'(halt), 16'h0000);
        reset = 1'b0;
    endtask

    task automatic run_program();
        apply_reset();
        while (halt !== 1'b1)
            step();
    endtask

    task automatic mov_imm_stores();
        logic [7:0] imm [8];
        clear_image();
        for (int i = 0; i < 8; i++)
            imm[3'(i)] = 8'($random(seed));
        imm[0]    = DATA_BASE;      // R0 is the store base
        imm[1][7] = 1'b1;           // At least one negative
        for (int i = 0; i < 8; i++)
            emit(mov_imm_word(3'(i), imm[3'(i)]));
        for (int i = 0; i < 8; i++)
            emit(str_word(3'd0, 3'(i), 5'(i)));
        // Random R0, stored through R7
        imm[0] = 8'($random(seed));
        emit(mov_imm_word(3'd7, DATA_BASE + 8'd8));
        emit(mov_imm_word(3'd0, imm[0]));
        emit(str_word(3'd7, 3'd0, 5'd0));
        emit(halt_word());
        run_program();
        check_word(9'(DATA_BASE), 16'(DATA_BASE));
        for (int i = 1; i < 8; i++)
            check_word(9'(DATA_BASE) + 9'(i), sext8(imm[3'(i)]));
        check_word(9'(DATA_BASE) + 9'd8, sext8(imm[0]));
    endtask

    task automatic alu_results();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [15:0] sa;
        logic [15:0] sb;
        a = 8'($random(seed));
        b = 8'($random(seed));
        clear_image();
        emit(mov_imm_word(3'd0, DATA_BASE));
        emit(mov_imm_word(3'd1, a));
        emit(mov_imm_word(3'd2, b));
        emit(mov_reg_word(3'd3, 3'd1));
        emit(alu_word(isa_pkg::ADD, 3'd1, 3'd4, 3'd2));
        emit(alu_word(isa_pkg::AND, 3'd1, 3'd5, 3'd2));
        emit(alu_word(isa_pkg::MVN, 3'd0, 3'd6, 3'd2));
        for (int i = 0; i < 4; i++)
            emit(str_word(3'd0, 3'(i + 3), 5'(i)));
        emit(halt_word());
        run_program();
        sa = sext8(a);
        sb = sext8(b);
        check_word(9'(DATA_BASE), sa);
        check_word(9'(DATA_BASE) + 9'd1, sa + sb);
        check_word(9'(DATA_BASE) + 9'd2, sa & sb);
        check_word(9'(DATA_BASE) + 9'd3, ~sb);
    endtask

    task automatic cmp_flags();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [15:0] av;
        logic [15:0] bv;
        logic [15:0] diff;
        int          wide;
        for (int round = 0; round < 4; round++)
        begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            if (round == 2)
                b = a;
            if (round == 3)
            begin
                a = 8'h7f;      // Large positive minus large negative
                b = 8'h80;
            end
            clear_image();
            emit(mov_imm_word(3'd1, a));
            emit(mov_imm_word(3'd2, b));
            repeat (8)
            begin
                emit(alu_word(isa_pkg::ADD, 3'd1, 3'd1, 3'd1));  // Doubling moves imm to the top byte
                emit(alu_word(isa_pkg::ADD, 3'd2, 3'd2, 3'd2));
            end
            emit(alu_word(isa_pkg::CMP, 3'd1, 3'd0, 3'd2));
            emit(halt_word());
            run_program();
            av   = {a, 8'h00};
            bv   = {b, 8'h00};
            diff = av - bv;
            wide = int'($signed(av)) - int'($signed(bv));
            check("status.n", 16'(status.n), 16'(diff[15]));
            check("status.z", 16'(status.z), 16'(diff == 16'h0000));
            check("status.v", 16'(status.v), 16'(wide > 32767 || wide < -32768));
        end
    endtask

    task automatic load_store_copy();
        logic [4:0]  off_a;
        logic [4:0]  off_b;
        logic [15:0] data_a;
        logic [15:0] data_b;
        logic [8:0]  src_a;
        logic [8:0]  src_b;
        off_a  = 5'($random(seed));
        off_b  = off_a ^ 5'h01;
        data_a = 16'($random(seed));
        data_b = 16'($random(seed));
        src_a  = 9'h050 + {{4{off_a[4]}}, off_a};   // imm5 may be negative
        src_b  = 9'h050 + {{4{off_b[4]}}, off_b};
        clear_image();
        image[src_a] = data_a;
        image[src_b] = data_b;
        emit(mov_imm_word(3'd0, 8'h50));
        emit(mov_imm_word(3'd1, DATA_BASE));
        emit(ldr_word(3'd0, 3'd3, off_a));
        emit(ldr_word(3'd0, 3'd4, off_b));
        emit(str_word(3'd1, 3'd3, 5'd0));
        emit(str_word(3'd1, 3'd4, 5'd1));
        emit(halt_word());
        run_program();
        check_word(9'(DATA_BASE), data_a);
        check_word(9'(DATA_BASE) + 9'd1, data_b);
    endtask

    // With scale set both operands move to the top byte, so the subtraction can overflow
    task automatic branch_case(isa_pkg::cond_e cond, logic [7:0] a, logic [7:0] b,
                               logic scale);
        logic taken;
        case (cond)
            isa_pkg::EQ: taken = (a == b);
            isa_pkg::NE: taken = (a != b);
            isa_pkg::LT: taken = ($signed(a) < $signed(b));
            isa_pkg::LE: taken = ($signed(a) <= $signed(b));
            default:     taken = 1'b1;
        endcase
        clear_image();
        emit(mov_imm_word(3'd0, DATA_BASE));
        emit(mov_imm_word(3'd1, a));
        emit(mov_imm_word(3'd2, b));
        if (scale)
        begin
            repeat (8)
            begin
                emit(alu_word(isa_pkg::ADD, 3'd1, 3'd1, 3'd1));
                emit(alu_word(isa_pkg::ADD, 3'd2, 3'd2, 3'd2));
            end
        end
        emit(alu_word(isa_pkg::CMP, 3'd1, 3'd0, 3'd2));
        emit(branch_word(cond, 8'd2));      // Target is the HALT
        emit(mov_imm_word(3'd3, 8'h5a));
        emit(str_word(3'd0, 3'd3, 5'd0));
        emit(halt_word());
        run_program();
        check($sformatf("mem[0x%h] after cond %0d with 0x%h, 0x%h", DATA_BASE, cond, a, b),
              mem[9'(DATA_BASE)], taken ? fill_word(9'(DATA_BASE)) : 16'h005a);
    endtask

    task automatic branch_conditions();
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] lo;
        logic [7:0] hi;
        x = 8'($random(seed));
        y = 8'($random(seed));
        if (y == x)
            y = x + 8'd1;
        if ($signed(x) < $signed(y))
        begin
            lo = x;
            hi = y;
        end
        else
        begin
            lo = y;
            hi = x;
        end
        branch_case(isa_pkg::ALWAYS, hi, lo, 1'b0);
        branch_case(isa_pkg::EQ, lo, lo, 1'b0);
        branch_case(isa_pkg::EQ, lo, hi, 1'b0);
        branch_case(isa_pkg::NE, hi, lo, 1'b0);
        branch_case(isa_pkg::NE, hi, hi, 1'b0);
        branch_case(isa_pkg::LT, lo, hi, 1'b0);
        branch_case(isa_pkg::LT, hi, lo, 1'b0);
        branch_case(isa_pkg::LE, hi, hi, 1'b0);
        branch_case(isa_pkg::LE, lo, hi, 1'b0);
        branch_case(isa_pkg::LE, hi, lo, 1'b0);
        // Overflowing subtractions, where N alone gives the wrong answer
        branch_case(isa_pkg::LT, 8'h80, 8'h7f, 1'b1);
        branch_case(isa_pkg::LT, 8'h7f, 8'h80, 1'b1);
        branch_case(isa_pkg::LE, 8'h7f, 8'h80, 1'b1);
    endtask

    task automatic halt_hold();
        int         writes_at_halt;
        logic [7:0] value;
        value = 8'($random(seed));
        clear_image();
        emit(mov_imm_word(3'd0, DATA_BASE));
        emit(mov_imm_word(3'd1, value));
        emit(str_word(3'd0, 3'd1, 5'd0));
        emit(halt_word());
        run_program();
        writes_at_halt = write_count;
        repeat (50)
        begin
            step();
            check("halt", 16'(halt), 16'h0001);
            check("mem_req.cmd", 16'(mem_req.cmd), 16'(bus_pkg::NONE));
        end
        check("write_count", 16'(write_count), 16'(writes_at_halt));
        check_word(9'(DATA_BASE), sext8(value));
        apply_reset();      // Checks halt low inside reset
    endtask

    initial
    begin
        reset    = 1'b1;
        load_mem = 1'b0;
        mov_imm_stores();
        alu_results();
        cmp_flags();
        load_store_copy();
        branch_conditions();
        halt_hold();
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== simple_risc.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/bus_pkg.sv
hdl/instr_decode.sv
hdl/fetch_unit.sv
hdl/control_fsm.sv
hdl/datapath.sv
hdl/simple_risc_top.sv
sim/tb_simple_risc.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = tb_simple_risc
FILELIST  = simple_risc.f

BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
